// File: source/sbus_params.svh
// sizes are fixed for two masters and three slaves; slave number 0 addresses no slave
`ifndef SBUS_PARAMS_SVH
`define SBUS_PARAMS_SVH

//////////////////////////////////////////////////
// interconnect sizing
//////////////////////////////////////////////////

// master 1 always wins over master 2
`define SBUS_NUM_MASTERS 2

// slaves are numbered 1 to SBUS_NUM_SLAVES
`define SBUS_NUM_SLAVES 3

// slave numbers are sent lsb first, one bit per cycle
`define SBUS_SLAVE_W 2

`endif

// File: source/sbus_pkg.sv
// bus_owner_t must stay wide enough for none plus every master; field order is the bus wire order
`include "sbus_params.svh"

package sbus_pkg;

    //////////////////////////////////////////////////
    // master and slave bundles
    //////////////////////////////////////////////////

    typedef logic [`SBUS_SLAVE_W-1:0] slave_num_t;

    typedef struct packed {
        logic request;    // held until grant is seen
        logic slave_sel;  // serial slave number, lsb first
        logic wr_data;
        logic wr_valid;
    } master_in_t;

    typedef struct packed {
        logic grant;
        logic rd_data;
        logic rd_valid;
    } master_out_t;

    typedef struct packed {
        logic select;
        logic wr_data;
        logic wr_valid;
    } slave_in_t;

    typedef struct packed {
        logic rd_data;
        logic rd_valid;
        logic done;       // one cycle pulse ends the transfer
        logic split;      // level, only one slave at a time
    } slave_out_t;

    typedef enum logic [$clog2(`SBUS_NUM_MASTERS+1)-1:0] {
        OWNER_NONE = 0,
        OWNER_M1   = 1,
        OWNER_M2   = 2
    } bus_owner_t;

    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_M1_REQ,
        ARB_M2_REQ,
        ARB_BUSY,
        ARB_SPLIT_IDLE,
        ARB_SPLIT_M1_GRANT,
        ARB_SPLIT_M2_GRANT,
        ARB_SPLIT_BUSY
    } arb_state_t;

endpackage

// File: source/sbus_addr_collect.sv
// both masters are sampled together; a collection only starts with arbiter and bus idle
`timescale 1ns/10ps
`include "sbus_params.svh"

module sbus_addr_collect
    import sbus_pkg::*;
(
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  master_in_t               m1_in,
    input  master_in_t               m2_in,
    input  logic                     arbiter_busy,
    input  logic                     bus_busy,
    output logic [`SBUS_SLAVE_W-1:0] rx_m1_slave,
    output logic [`SBUS_SLAVE_W-1:0] rx_m2_slave,
    output logic                     sel_done
);

    // 0 is idle, 1 to W-1 are the later bits, W is done
    logic [$clog2(`SBUS_SLAVE_W+1)-1:0] bit_cnt;
    logic                               start;
    logic                               shift_en;

    assign start = (m1_in.request | m2_in.request) & ~arbiter_busy & ~bus_busy;

    assign shift_en = (bit_cnt == 0) ? start : (bit_cnt != `SBUS_SLAVE_W);

    //////////////////////////////////////////////////
    // bit counter and done pulse
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk or posedge sys_rst)
    begin
        if (sys_rst)
        begin
            bit_cnt  <= '0;
            sel_done <= 1'b0;
        end
        else
        begin
            sel_done <= 1'b0;
            if (bit_cnt == `SBUS_SLAVE_W)
            begin
                bit_cnt  <= '0;
                sel_done <= 1'b1;  // seen by the arbiter one edge later
            end
            else if (shift_en)
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge sys_clk)
    begin
        if (shift_en)
        begin
            rx_m1_slave <= {m1_in.slave_sel, rx_m1_slave[`SBUS_SLAVE_W-1:1]};
            rx_m2_slave <= {m2_in.slave_sel, rx_m2_slave[`SBUS_SLAVE_W-1:1]};
        end
    end

endmodule

// File: source/sbus_arbiter.sv
// master 1 has fixed priority; one split is parked at a time and a stuck slave hangs the bus
`timescale 1ns/10ps
`include "sbus_params.svh"

module sbus_arbiter
    import sbus_pkg::*;
(
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  logic                     m1_request,
    input  logic                     m2_request,
    input  logic [`SBUS_SLAVE_W-1:0] rx_m1_slave,
    input  logic [`SBUS_SLAVE_W-1:0] rx_m2_slave,
    input  logic                     sel_done,
    input  logic                     trans_done,
    input  logic                     split_active,
    output logic                     m1_grant,
    output logic                     m2_grant,
    output logic                     arbiter_busy,
    output logic                     bus_busy,
    output bus_owner_t               bus_grant,
    output logic [`SBUS_SLAVE_W-1:0] slave_sel
);

    arb_state_t               state;
    bus_owner_t               saved_owner;  // owner parked by a split
    logic [`SBUS_SLAVE_W-1:0] saved_slave;

    //////////////////////////////////////////////////
    // grant state machine
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk or posedge sys_rst)
    begin
        if (sys_rst)
        begin
            state        <= ARB_IDLE;
            m1_grant     <= 1'b0;
            m2_grant     <= 1'b0;
            arbiter_busy <= 1'b0;
            bus_busy     <= 1'b0;
            bus_grant    <= OWNER_NONE;
            slave_sel    <= '0;
            saved_owner  <= OWNER_NONE;
            saved_slave  <= '0;
        end
        else
        begin
            case (state)
                ARB_IDLE:
                begin
                    if (m1_request)
                    begin
                        state        <= ARB_M1_REQ;  // priority
                        arbiter_busy <= 1'b1;
                    end
                    else if (m2_request)
                    begin
                        state        <= ARB_M2_REQ;
                        arbiter_busy <= 1'b1;
                    end
                    else
                    begin
                        arbiter_busy <= 1'b0;
                        bus_busy     <= 1'b0;
                    end
                end

                ARB_M1_REQ:
                begin
                    if (sel_done)
                    begin
                        state        <= ARB_BUSY;
                        bus_grant    <= OWNER_M1;
                        m1_grant     <= 1'b1;
                        m2_grant     <= 1'b0;
                        slave_sel    <= rx_m1_slave;
                        arbiter_busy <= 1'b0;
                        bus_busy     <= 1'b1;
                    end
                end

                ARB_M2_REQ:
                begin
                    if (sel_done)
                    begin
                        state        <= ARB_BUSY;
                        bus_grant    <= OWNER_M2;
                        m1_grant     <= 1'b0;
                        m2_grant     <= 1'b1;
                        slave_sel    <= rx_m2_slave;
                        arbiter_busy <= 1'b0;
                        bus_busy     <= 1'b1;
                    end
                end

                ARB_BUSY:
                begin
                    if (trans_done)
                    begin
                        state     <= ARB_IDLE;
                        m1_grant  <= 1'b0;
                        m2_grant  <= 1'b0;
                        bus_grant <= OWNER_NONE;
                        slave_sel <= '0;
                        bus_busy  <= 1'b0;
                    end
                    else if (split_active)
                    begin
                        state       <= ARB_SPLIT_IDLE;
                        saved_owner <= bus_grant;  // park the owner
                        saved_slave <= slave_sel;
                        m1_grant    <= 1'b0;
                        m2_grant    <= 1'b0;
                        bus_grant   <= OWNER_NONE;
                        slave_sel   <= '0;
                        bus_busy    <= 1'b0;
                    end
                end

                // split cleared wins over new requests, so a refused master cannot starve the restore
                ARB_SPLIT_IDLE:
                begin
                    if (!split_active)
                    begin
                        state     <= ARB_BUSY;
                        bus_grant <= saved_owner;
                        m1_grant  <= (saved_owner == OWNER_M1);
                        m2_grant  <= (saved_owner == OWNER_M2);
                        slave_sel <= saved_slave;
                        bus_busy  <= 1'b1;
                    end
                    else if (m1_request && saved_owner != OWNER_M1)
                    begin
                        state        <= ARB_SPLIT_M1_GRANT;
                        arbiter_busy <= 1'b1;
                    end
                    else if (m2_request && saved_owner != OWNER_M2)
                    begin
                        state        <= ARB_SPLIT_M2_GRANT;
                        arbiter_busy <= 1'b1;
                    end
                    else
                    begin
                        arbiter_busy <= 1'b0;
                    end
                end

                ARB_SPLIT_M1_GRANT:
                begin
                    if (sel_done)
                    begin
                        arbiter_busy <= 1'b0;
                        if (rx_m1_slave != saved_slave)
                        begin
                            state     <= ARB_SPLIT_BUSY;
                            bus_grant <= OWNER_M1;
                            m1_grant  <= 1'b1;
                            m2_grant  <= 1'b0;
                            slave_sel <= rx_m1_slave;
                            bus_busy  <= 1'b1;
                        end
                        else
                        begin
                            state <= ARB_SPLIT_IDLE;  // parked slave refused
                        end
                    end
                end

                ARB_SPLIT_M2_GRANT:
                begin
                    if (sel_done)
                    begin
                        arbiter_busy <= 1'b0;
                        if (rx_m2_slave != saved_slave)
                        begin
                            state     <= ARB_SPLIT_BUSY;
                            bus_grant <= OWNER_M2;
                            m1_grant  <= 1'b0;
                            m2_grant  <= 1'b1;
                            slave_sel <= rx_m2_slave;
                            bus_busy  <= 1'b1;
                        end
                        else
                        begin
                            state <= ARB_SPLIT_IDLE;
                        end
                    end
                end

                ARB_SPLIT_BUSY:
                begin
                    if (trans_done)
                    begin
                        state     <= ARB_BUSY;  // back to the parked transfer
                        bus_grant <= saved_owner;
                        m1_grant  <= (saved_owner == OWNER_M1);
                        m2_grant  <= (saved_owner == OWNER_M2);
                        slave_sel <= saved_slave;
                    end
                end

                default:
                begin
                    state        <= ARB_IDLE;
                    m1_grant     <= 1'b0;
                    m2_grant     <= 1'b0;
                    arbiter_busy <= 1'b0;
                    bus_busy     <= 1'b0;
                    bus_grant    <= OWNER_NONE;
                    slave_sel    <= '0;
                end
            endcase
        end
    end

endmodule

// File: source/sbus_route.sv
// purely combinational; slave number 0 or no owner selects nothing and returns no done
`timescale 1ns/10ps
`include "sbus_params.svh"

module sbus_route
    import sbus_pkg::*;
(
    input  bus_owner_t  bus_grant,
    input  slave_num_t  slave_sel,
    input  master_in_t  m1_in,
    input  master_in_t  m2_in,
    input  slave_out_t  s1_out,
    input  slave_out_t  s2_out,
    input  slave_out_t  s3_out,
    input  logic        m1_grant,
    input  logic        m2_grant,
    output slave_in_t   s1_in,
    output slave_in_t   s2_in,
    output slave_in_t   s3_in,
    output master_out_t m1_out,
    output master_out_t m2_out,
    output logic        trans_done,
    output logic        split_active
);

    logic [`SBUS_NUM_SLAVES-1:0] slave_onehot;
    master_in_t                  owner_in;
    slave_out_t                  slave_out [`SBUS_NUM_SLAVES];
    slave_in_t                   slave_in  [`SBUS_NUM_SLAVES];
    slave_out_t                  sel_out;

    assign slave_out[0] = s1_out;
    assign slave_out[1] = s2_out;
    assign slave_out[2] = s3_out;

    assign owner_in = (bus_grant == OWNER_M1) ? m1_in :
                      (bus_grant == OWNER_M2) ? m2_in : '0;

    //////////////////////////////////////////////////
    // slave select and return mux
    //////////////////////////////////////////////////

    always_comb
    begin
        sel_out      = '0;
        split_active = 1'b0;
        for (int i = 0; i < `SBUS_NUM_SLAVES; i++)
        begin
            slave_onehot[i]      = (bus_grant != OWNER_NONE) && (slave_sel == slave_num_t'(i + 1));
            slave_in[i].select   = slave_onehot[i];
            slave_in[i].wr_data  = owner_in.wr_data & slave_onehot[i];
            slave_in[i].wr_valid = owner_in.wr_valid & slave_onehot[i];
            sel_out              = sel_out | (slave_onehot[i] ? slave_out[i] : '0);
            split_active         = split_active | slave_out[i].split;  // any slave, selected or not
        end
    end

    assign s1_in = slave_in[0];
    assign s2_in = slave_in[1];
    assign s3_in = slave_in[2];

    assign trans_done = sel_out.done;

    // read bits only reach the owner
    assign m1_out.grant    = m1_grant;
    assign m1_out.rd_data  = sel_out.rd_data & (bus_grant == OWNER_M1);
    assign m1_out.rd_valid = sel_out.rd_valid & (bus_grant == OWNER_M1);
    assign m2_out.grant    = m2_grant;
    assign m2_out.rd_data  = sel_out.rd_data & (bus_grant == OWNER_M2);
    assign m2_out.rd_valid = sel_out.rd_valid & (bus_grant == OWNER_M2);

endmodule

// File: source/sbus_interconnect.sv
// masters must never send slave number 0, since that transfer waits forever for done
`timescale 1ns/10ps
`include "sbus_params.svh"

module sbus_interconnect
    import sbus_pkg::*;
(
    input  logic        sys_clk,
    input  logic        sys_rst,
    input  master_in_t  m1_in,
    input  master_in_t  m2_in,
    input  slave_out_t  s1_out,
    input  slave_out_t  s2_out,
    input  slave_out_t  s3_out,
    output master_out_t m1_out,
    output master_out_t m2_out,
    output slave_in_t   s1_in,
    output slave_in_t   s2_in,
    output slave_in_t   s3_in,
    output logic        arbiter_busy,
    output logic        bus_busy,
    output bus_owner_t  bus_grant,
    output slave_num_t  slave_sel
);

    slave_num_t rx_m1_slave;
    slave_num_t rx_m2_slave;
    logic       sel_done;
    logic       m1_grant;
    logic       m2_grant;
    logic       trans_done;
    logic       split_active;

    //////////////////////////////////////////////////
    // collect, arbitrate, route
    //////////////////////////////////////////////////

    sbus_addr_collect u_addr_collect (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .m1_in        (m1_in),
        .m2_in        (m2_in),
        .arbiter_busy (arbiter_busy),
        .bus_busy     (bus_busy),
        .rx_m1_slave  (rx_m1_slave),
        .rx_m2_slave  (rx_m2_slave),
        .sel_done     (sel_done)
    );

    sbus_arbiter u_arbiter (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .m1_request   (m1_in.request),
        .m2_request   (m2_in.request),
        .rx_m1_slave  (rx_m1_slave),
        .rx_m2_slave  (rx_m2_slave),
        .sel_done     (sel_done),
        .trans_done   (trans_done),
        .split_active (split_active),
        .m1_grant     (m1_grant),
        .m2_grant     (m2_grant),
        .arbiter_busy (arbiter_busy),
        .bus_busy     (bus_busy),
        .bus_grant    (bus_grant),
        .slave_sel    (slave_sel)
    );

    sbus_route u_route (
        .bus_grant    (bus_grant),
        .slave_sel    (slave_sel),
        .m1_in        (m1_in),
        .m2_in        (m2_in),
        .s1_out       (s1_out),
        .s2_out       (s2_out),
        .s3_out       (s3_out),
        .m1_grant     (m1_grant),
        .m2_grant     (m2_grant),
        .s1_in        (s1_in),
        .s2_in        (s2_in),
        .s3_in        (s3_in),
        .m1_out       (m1_out),
        .m2_out       (m2_out),
        .trans_done   (trans_done),
        .split_active (split_active)
    );

endmodule

// File: bench/sbus_interconnect_tb.sv
// masters and slaves are modelled in the bench; slave 3 is the only parked slave a refused master may target
`timescale 1ns/10ps
`include "sbus_params.svh"

module sbus_interconnect_tb
    import sbus_pkg::*;
();

    typedef struct packed {
        logic       m1_req;
        logic       m2_req;
        slave_num_t m1_slave;
        slave_num_t m2_slave;
        slave_num_t split_slave;  // 0 means no split in this row
        logic       split_late;   // drop split after a refused request
        bus_owner_t exp_owner;
        slave_num_t exp_sel;
    } row_t;

    localparam int NUM_ROWS        = 9;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + 20;
    localparam int GRANT_TIMEOUT   = 20;

    logic        sys_clk;
    logic        sys_rst;
    master_in_t  m_in  [2];
    master_out_t m_out [2];
    slave_out_t  s_out [`SBUS_NUM_SLAVES];
    slave_in_t   s_in  [`SBUS_NUM_SLAVES];
    logic        arbiter_busy;
    logic        bus_busy;
    bus_owner_t  bus_grant;
    slave_num_t  slave_sel;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr_state;
    int          row_errors;
    int          rows_passed;
    int          rows_failed;

    sbus_interconnect u_sbus_interconnect (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .m1_in        (m_in[0]),
        .m2_in        (m_in[1]),
        .s1_out       (s_out[0]),
        .s2_out       (s_out[1]),
        .s3_out       (s_out[2]),
        .m1_out       (m_out[0]),
        .m2_out       (m_out[1]),
        .s1_in        (s_in[0]),
        .s2_in        (s_in[1]),
        .s3_in        (s_in[2]),
        .arbiter_busy (arbiter_busy),
        .bus_busy     (bus_busy),
        .bus_grant    (bus_grant),
        .slave_sel    (slave_sel)
    );

    always #20 sys_clk = ~sys_clk;

    initial
    begin
        #(WATCHDOG_CYCLES * 40);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // helpers and compare tasks
    //////////////////////////////////////////////////

    task automatic tick();
        @(posedge sys_clk);
        #2;  // drive point, outputs settled
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic rand_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    task automatic compare_owner(input string name, input bus_owner_t got, input bus_owner_t exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic compare_slave_num(input string name, input slave_num_t got,
                                     input slave_num_t exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic compare_master_out(input string name, input master_out_t got,
                                      input master_out_t exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic compare_slave_in(input string name, input slave_in_t got,
                                    input slave_in_t exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error %s got %h expected %h", name, got, exp);
            row_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // master and slave actions
    //////////////////////////////////////////////////

    // raise requests, send numbers lsb first and wait for who's grant
    task automatic request_and_wait(input logic [1:0] mask, input bus_owner_t who,
                                    input slave_num_t n1, input slave_num_t n2);
        int n;
        int idx;
        n   = 0;
        idx = int'(who) - 1;
        if (mask[0])
        begin
            m_in[0].request   = 1'b1;
            m_in[0].slave_sel = n1[0];
        end
        if (mask[1])
        begin
            m_in[1].request   = 1'b1;
            m_in[1].slave_sel = n2[0];
        end
        while (m_out[idx].grant !== 1'b1 && n < GRANT_TIMEOUT)
        begin
            tick();
            n++;
            if (n == 1)
            begin
                if (mask[0])
                    m_in[0].slave_sel = n1[1];
                if (mask[1])
                    m_in[1].slave_sel = n2[1];
            end
        end
        if (m_out[idx].grant !== 1'b1)
        begin
            $display("grant for master %0d never arrived", idx + 1);
            row_errors++;
        end
        else
        begin
            if (n - 1 != 3)
            begin
                $display("** Error grant_latency got %h expected %h", n - 1, 3);
                row_errors++;
            end
            m_in[idx].request = 1'b0;  // grant seen
        end
    endtask

    // random write and read bits, checked against the routing rules
    task automatic check_transfer(input bus_owner_t who, input slave_num_t s, input int cycles);
        slave_in_t   exp_si;
        master_out_t exp_mo;
        for (int c = 0; c < cycles; c++)
        begin
            for (int m = 0; m < 2; m++)
            begin
                m_in[m].wr_data  = rand_bit();
                m_in[m].wr_valid = rand_bit();
            end
            for (int j = 0; j < `SBUS_NUM_SLAVES; j++)
            begin
                s_out[j].rd_data  = rand_bit();
                s_out[j].rd_valid = rand_bit();
            end
            #1;
            for (int j = 0; j < `SBUS_NUM_SLAVES; j++)
            begin
                exp_si.select   = (j + 1 == int'(s));
                exp_si.wr_data  = m_in[int'(who) - 1].wr_data & exp_si.select;
                exp_si.wr_valid = m_in[int'(who) - 1].wr_valid & exp_si.select;
                compare_slave_in($sformatf("s%0d_in", j + 1), s_in[j], exp_si);
            end
            for (int m = 0; m < 2; m++)
            begin
                exp_mo = '0;
                if (m == int'(who) - 1)
                begin
                    exp_mo.grant    = 1'b1;
                    exp_mo.rd_data  = s_out[int'(s) - 1].rd_data;
                    exp_mo.rd_valid = s_out[int'(s) - 1].rd_valid;
                end
                compare_master_out($sformatf("m%0d_out", m + 1), m_out[m], exp_mo);
            end
            tick();
        end
        for (int m = 0; m < 2; m++)
            m_in[m] = '{request: m_in[m].request, default: 1'b0};
    endtask

    // done pulse on slave s; the bus is free on the next edge
    task automatic finish_transfer(input slave_num_t s);
        s_out[int'(s) - 1].done = 1'b1;
        tick();
        s_out[int'(s) - 1].done = 1'b0;
        compare_owner("bus_grant", bus_grant, OWNER_NONE);
        compare_flag("bus_busy", bus_busy, 1'b0);
        compare_flag("m1_grant", m_out[0].grant, 1'b0);
        compare_flag("m2_grant", m_out[1].grant, 1'b0);
    endtask

    task automatic run_row(input row_t r);
        int n;
        if (r.split_slave == 0)
        begin
            request_and_wait({r.m2_req, r.m1_req}, r.exp_owner, r.m1_slave, r.m2_slave);
            compare_owner("bus_grant", bus_grant, r.exp_owner);
            compare_slave_num("slave_sel", slave_sel, r.exp_sel);
            check_transfer(r.exp_owner, r.exp_sel, 4);
            finish_transfer(r.exp_sel);
            if (r.m1_req && r.m2_req)
            begin
                // master 2 kept requesting and resends its number
                request_and_wait(2'b10, OWNER_M2, r.m1_slave, r.m2_slave);
                compare_owner("bus_grant", bus_grant, OWNER_M2);
                compare_slave_num("slave_sel", slave_sel, r.m2_slave);
                check_transfer(OWNER_M2, r.m2_slave, 4);
                finish_transfer(r.m2_slave);
            end
        end
        else
        begin
            request_and_wait(2'b01, OWNER_M1, r.m1_slave, r.m2_slave);
            compare_owner("bus_grant", bus_grant, r.exp_owner);
            compare_slave_num("slave_sel", slave_sel, r.exp_sel);
            check_transfer(OWNER_M1, r.split_slave, 3);
            s_out[int'(r.split_slave) - 1].split = 1'b1;
            tick();
            compare_owner("bus_grant", bus_grant, OWNER_NONE);
            compare_flag("m1_grant", m_out[0].grant, 1'b0);
            if (!r.split_late)
            begin
                request_and_wait(2'b10, OWNER_M2, r.m1_slave, r.m2_slave);
                compare_owner("bus_grant", bus_grant, OWNER_M2);
                compare_slave_num("slave_sel", slave_sel, r.m2_slave);
                check_transfer(OWNER_M2, r.m2_slave, 3);
                s_out[int'(r.m2_slave) - 1].done   = 1'b1;
                s_out[int'(r.split_slave) - 1].split = 1'b0;
                tick();
                s_out[int'(r.m2_slave) - 1].done = 1'b0;
            end
            else
            begin
                m_in[1].request   = 1'b1;
                m_in[1].slave_sel = r.m2_slave[0];
                for (n = 0; n < 12; n++)
                begin
                    tick();
                    m_in[1].slave_sel = r.m2_slave[1];
                    compare_flag("m2_grant", m_out[1].grant, 1'b0);
                end
                m_in[1].request = 1'b0;
                s_out[int'(r.split_slave) - 1].split = 1'b0;
                n = 0;
                while (bus_grant !== OWNER_M1 && n < GRANT_TIMEOUT)
                begin
                    tick();
                    n++;
                end
                if (bus_grant !== OWNER_M1)
                begin
                    $display("parked master 1 was not restored after the split cleared");
                    row_errors++;
                end
            end
            compare_owner("bus_grant", bus_grant, OWNER_M1);
            compare_slave_num("slave_sel", slave_sel, r.split_slave);
            check_transfer(OWNER_M1, r.split_slave, 2);
            finish_transfer(r.split_slave);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        sys_clk     = 1'b0;
        sys_rst     = 1'b1;
        lfsr_state  = 32'h92b525e3;
        rows_passed = 0;
        rows_failed = 0;
        for (int m = 0; m < 2; m++)
            m_in[m] = '0;
        for (int j = 0; j < `SBUS_NUM_SLAVES; j++)
            s_out[j] = '0;

        //           m1 m2 m1s m2s split late owner     sel
        rows[0] = '{1'b1, 1'b0, 2'd1, 2'd0, 2'd0, 1'b0, OWNER_M1, 2'd1};
        rows[1] = '{1'b0, 1'b1, 2'd0, 2'd2, 2'd0, 1'b0, OWNER_M2, 2'd2};
        rows[2] = '{1'b1, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, OWNER_M1, 2'd3};
        rows[3] = '{1'b0, 1'b1, 2'd0, 2'd3, 2'd0, 1'b0, OWNER_M2, 2'd3};
        rows[4] = '{1'b1, 1'b1, 2'd2, 2'd1, 2'd0, 1'b0, OWNER_M1, 2'd2};
        rows[5] = '{1'b1, 1'b1, 2'd1, 2'd1, 2'd0, 1'b0, OWNER_M1, 2'd1};
        rows[6] = '{1'b1, 1'b1, 2'd1, 2'd2, 2'd1, 1'b0, OWNER_M1, 2'd1};
        rows[7] = '{1'b1, 1'b1, 2'd2, 2'd3, 2'd2, 1'b0, OWNER_M1, 2'd2};
        rows[8] = '{1'b1, 1'b1, 2'd3, 2'd3, 2'd3, 1'b1, OWNER_M1, 2'd3};

        repeat (4) @(posedge sys_clk);
        #2;
        sys_rst = 1'b0;
        tick();

        row_errors = 0;
        compare_owner("bus_grant", bus_grant, OWNER_NONE);
        compare_slave_num("slave_sel", slave_sel, '0);
        compare_flag("bus_busy", bus_busy, 1'b0);
        compare_flag("arbiter_busy", arbiter_busy, 1'b0);
        for (int m = 0; m < 2; m++)
            compare_master_out($sformatf("m%0d_out", m + 1), m_out[m], '0);
        for (int j = 0; j < `SBUS_NUM_SLAVES; j++)
            compare_slave_in($sformatf("s%0d_in", j + 1), s_in[j], '0);
        if (row_errors == 0)
            rows_passed++;
        else
            rows_failed++;
        $display("reset check: %0d errors", row_errors);

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            row_errors = 0;
            run_row(rows[i]);
            repeat (3) tick();  // let the collector settle
            if (row_errors == 0)
                rows_passed++;
            else
                rows_failed++;
            $display("row %0d: %0d errors", i, row_errors);
        end

        $display("tests passed %0d, failed %0d", rows_passed, rows_failed);
        if (rows_failed == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: sbus_interconnect.f
+incdir+source
source/sbus_pkg.sv
source/sbus_addr_collect.sv
source/sbus_arbiter.sv
source/sbus_route.sv
source/sbus_interconnect.sv
bench/sbus_interconnect_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the interconnect testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
    -f sbus_interconnect.f \
    --top-module sbus_interconnect_tb \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
